// ==== Makefile ====
# Verilator build and run for the zzzap control input path.

VERILATOR ?= verilator
TOP       ?= zzzap_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SRCS := verilog/zzzap_pkg.sv \
	verilog/control_ramp.sv \
	verilog/sample_fifo.sv \
	verilog/input_port_mux.sv \
	verilog/zzzap_controls.sv \
	verif/zzzap_tb.sv

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
verilog/zzzap_pkg.sv
verilog/control_ramp.sv
verilog/sample_fifo.sv
verilog/input_port_mux.sv
verilog/zzzap_controls.sv
verif/zzzap_tb.sv

// ==== verif/zzzap_tb.sv ====
`timescale 1ns/100ps

module zzzap_tb;

	localparam int MAX_ROWS  = 128;
	localparam int MAX_RD    = 16;
	localparam int RAND_ROWS = 24;

	logic             clk_core;
	logic             rst;
	logic             vsync;
	logic             gas_plus;
	logic             gas_minus;
	logic             steer_plus;
	logic             steer_minus;
	logic             gear_btn;
	logic             port_rd;
	zzzap_pkg::port_e port_sel;
	logic             rd_valid;
	logic [7:0]       rd_data;

	// one row per button setting with levels, frames and port reads.
	logic [4:0]       btn_tab   [MAX_ROWS];  // gear, steer_minus, steer_plus, gas_minus, gas_plus.
	int               frame_tab [MAX_ROWS];
	int               nrd_tab   [MAX_ROWS];
	zzzap_pkg::port_e port_tab  [MAX_ROWS][MAX_RD];
	logic [7:0]       exp_tab   [MAX_ROWS][MAX_RD];
	int               nrows;

	// reference model is advanced once per frame.
	int          m_steer;
	int          m_pedal;
	logic        m_gear;
	logic        m_gear_btn;
	logic [16:0] m_fifo [$];
	logic        m_pending;
	logic [16:0] m_pend;
	logic [16:0] m_latch;

	integer seed;
	int     val_errors;
	int     proto_errors;
	int     wd_cycles;

	zzzap_controls dut_i (
		.clk_core    (clk_core),
		.rst         (rst),
		.vsync       (vsync),
		.gas_plus    (gas_plus),
		.gas_minus   (gas_minus),
		.steer_plus  (steer_plus),
		.steer_minus (steer_minus),
		.gear_btn    (gear_btn),
		.port_rd     (port_rd),
		.port_sel    (port_sel),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

	always #10 clk_core = ~clk_core;

	function automatic zzzap_pkg::port_e port_of(input byte c);
		case (c)
			"S":     return zzzap_pkg::PORT_STEER;
			"P":     return zzzap_pkg::PORT_PEDAL;
			"D":     return zzzap_pkg::PORT_DIP;
			default: return zzzap_pkg::PORT_LATCH;
		endcase
	endfunction

	task automatic add_row(input logic [4:0] btn, input int frames, input string reads);
		int i;
		btn_tab[nrows]   = btn;
		frame_tab[nrows] = frames;
		nrd_tab[nrows]   = reads.len();
		for (i = 0; i < reads.len(); i++)
			port_tab[nrows][i] = port_of(reads[i]);
		nrows++;
	endtask

	// wheel and pedal step, then the sample goes to the queue or the pending slot.
	task automatic model_frame(input logic [4:0] btn);
		logic [16:0] smp;
		if (btn[2] && !btn[3])
			m_steer = (m_steer + 8 > 64) ? 64 : m_steer + 8;
		else if (btn[3] && !btn[2])
			m_steer = (m_steer - 8 < -64) ? -64 : m_steer - 8;
		else if (m_steer > 0)
			m_steer = (m_steer < 8) ? 0 : m_steer - 8;    // drift to centre.
		else if (m_steer < 0)
			m_steer = (m_steer > -8) ? 0 : m_steer + 8;
		if (btn[0] && !btn[1])
			m_pedal = (m_pedal + 16 > 240) ? 240 : m_pedal + 16;
		else if (btn[1] && !btn[0])
			m_pedal = (m_pedal < 16) ? 0 : m_pedal - 16;
		smp = {m_gear, 8'(m_pedal), 8'(m_steer)};
		if (m_fifo.size() < 4 && !m_pending) begin
			m_fifo.push_back(smp);
		end else begin
			m_pending = 1'b1;   // newest frame wins.
			m_pend    = smp;
		end
	endtask

	function automatic logic [7:0] model_read(input zzzap_pkg::port_e sel);
		logic [7:0] st;
		case (sel)
			zzzap_pkg::PORT_LATCH: begin
				if (m_fifo.size() == 0)
					return 8'h00;
				m_latch = m_fifo.pop_front();
				if (m_pending) begin
					m_fifo.push_back(m_pend);   // freed credit sends the pending one.
					m_pending = 1'b0;
				end
				return 8'h01;
			end
			zzzap_pkg::PORT_STEER: begin
				st = m_latch[7:0] + 8'd16;
				return 8'd0 - st;
			end
			zzzap_pkg::PORT_PEDAL:
				return {3'b000, m_latch[16], m_latch[15:12]};
			default:
				return 8'h3C;
		endcase
	endfunction

	task automatic pulse_vsync();
		vsync = 1'b1;
		repeat (2) @(negedge clk_core);
		vsync = 1'b0;
		repeat (6) @(negedge clk_core);
	endtask

	// starts on a falling edge and leaves two idle cycles behind the read.
	task automatic run_read(input zzzap_pkg::port_e sel, input logic [7:0] exp, input int row);
		port_sel = sel;
		port_rd  = 1'b1;
		@(negedge clk_core);
		port_rd = 1'b0;
		assert (rd_valid === 1'b1) else begin
			proto_errors++;
			$display("row %0d: no rd_valid one cycle after a read of %s", row, sel.name());
		end
		if (rd_valid === 1'b1) begin
			assert (rd_data === exp) else begin
				val_errors++;
				$display("[FAIL] row %0d %s: rd_data expected 0x%02h, got 0x%02h",
					row, sel.name(), exp, rd_data);
			end
		end
		@(negedge clk_core);
		assert (rd_valid === 1'b0) else begin
			proto_errors++;
			$display("row %0d: rd_valid stayed high longer than one cycle", row);
		end
		@(negedge clk_core);
	endtask

	task automatic apply_row(input int r);
		int f;
		int k;
		{gear_btn, steer_minus, steer_plus, gas_minus, gas_plus} = btn_tab[r];
		repeat (4) @(negedge clk_core);    // gear edge settles before the first frame.
		for (f = 0; f < frame_tab[r]; f++)
			pulse_vsync();
		@(negedge clk_core);
		for (k = 0; k < nrd_tab[r]; k++)
			run_read(port_tab[r][k], exp_tab[r][k], r);
	endtask

	initial begin
		int          r;
		int          f;
		int          k;
		logic [31:0] rnd;
		string       rd;
		clk_core     = 1'b0;
		rst          = 1'b1;
		vsync        = 1'b0;
		gas_plus     = 1'b0;
		gas_minus    = 1'b0;
		steer_plus   = 1'b0;
		steer_minus  = 1'b0;
		gear_btn     = 1'b0;
		port_rd      = 1'b0;
		port_sel     = zzzap_pkg::PORT_LATCH;
		seed         = 32'hceaa3f1c;
		val_errors   = 0;
		proto_errors = 0;
		nrows        = 0;

		add_row(5'b00000, 0, "LSPD");               // values out of reset.
		repeat (10) add_row(5'b00100, 1, "LS");     // full right, then saturate.
		repeat (9) add_row(5'b00000, 1, "LS");
		repeat (10) add_row(5'b01000, 1, "LS");     // full left.
		repeat (4) add_row(5'b00000, 1, "LS");
		repeat (5) add_row(5'b01100, 1, "LSD");     // both held acts as released.
		repeat (16) add_row(5'b00001, 1, "LPD");
		add_row(5'b00000, 2, "LPLP");               // pedal holds.
		repeat (3) begin
			add_row(5'b10000, 1, "LP");
			add_row(5'b00000, 1, "LPD");
		end
		repeat (16) add_row(5'b00010, 1, "LP");
		add_row(5'b00100, 6, "");                   // no latch for six frames.
		add_row(5'b00000, 0, "LSLSLSLSLSLD");

		for (r = 0; r < RAND_ROWS; r++) begin
			rnd = $random(seed);
			rd  = "";
			repeat (int'(rnd[9:8]) + 1) rd = {rd, "LSP"};
			rd = {rd, "D"};
			add_row(rnd[4:0], int'(rnd[9:8]), rd);
		end

		m_steer    = 0;
		m_pedal    = 0;
		m_gear     = 1'b0;
		m_gear_btn = 1'b0;
		m_pending  = 1'b0;
		m_pend     = '0;
		m_latch    = '0;
		for (r = 0; r < nrows; r++) begin
			if (btn_tab[r][4] && !m_gear_btn)
				m_gear = ~m_gear;
			m_gear_btn = btn_tab[r][4];
			for (f = 0; f < frame_tab[r]; f++)
				model_frame(btn_tab[r]);
			for (k = 0; k < nrd_tab[r]; k++)
				exp_tab[r][k] = model_read(port_tab[r][k]);
		end
		wd_cycles = nrows * 8 * 8 + 500;

		repeat (16) @(negedge clk_core);
		rst = 1'b0;
		@(negedge clk_core);

		for (r = 0; r < nrows; r++)
			apply_row(r);

		$display("errors: %0d wrong values, %0d protocol", val_errors, proto_errors);
		if (val_errors == 0 && proto_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog.
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk_core);
		$display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== verilog/control_ramp.sv ====
`timescale 1ns/100ps

// turns the four direction buttons into a wheel and pedal position that
// move one step per frame, and the fire button into a two-speed gear.
module control_ramp (
	input  logic                           clk_core,
	input  logic                           rst,
	input  logic                           vsync,
	input  logic                           gas_plus,
	input  logic                           gas_minus,
	input  logic                           steer_plus,
	input  logic                           steer_minus,
	input  logic                           gear_btn,
	input  logic                           credit_return,
	output logic                           push,
	output logic [zzzap_pkg::SAMPLE_W-1:0] push_data
);

	logic vsync_r;
	logic vsync_d;
	logic frame;
	logic gear_r;
	logic gear_d;
	logic gear_edge;
	logic gear;

	logic signed [zzzap_pkg::STEER_W-1:0] steering;
	logic signed [zzzap_pkg::STEER_W-1:0] steer_next;
	logic [zzzap_pkg::PEDAL_W-1:0]        pedal;
	logic [zzzap_pkg::PEDAL_W-1:0]        pedal_next;

	logic                           pending;
	logic [zzzap_pkg::SAMPLE_W-1:0] pend_data;
	logic [zzzap_pkg::CREDIT_W-1:0] credits;
	logic                           send;

	assign frame     = vsync_r & ~vsync_d;   // one cycle per frame.
	assign gear_edge = gear_r & ~gear_d;

	// a returning credit can be spent in the cycle it arrives.
	assign send = pending & ((credits != '0) | credit_return);

	// steering steps while one button is held and drifts back to centre otherwise.
	always_comb begin
		steer_next = steering;
		if (steer_plus && !steer_minus) begin
			if (steering > zzzap_pkg::STEER_MAX - zzzap_pkg::STEER_STEP)
				steer_next = zzzap_pkg::STEER_MAX;
			else
				steer_next = steering + zzzap_pkg::STEER_STEP;
		end else if (steer_minus && !steer_plus) begin
			if (steering < zzzap_pkg::STEER_MIN + zzzap_pkg::STEER_STEP)
				steer_next = zzzap_pkg::STEER_MIN;
			else
				steer_next = steering - zzzap_pkg::STEER_STEP;
		end else if (steering > zzzap_pkg::STEER_CENTRE) begin
			if (steering < zzzap_pkg::STEER_STEP)
				steer_next = zzzap_pkg::STEER_CENTRE;
			else
				steer_next = steering - zzzap_pkg::STEER_STEP;
		end else if (steering < zzzap_pkg::STEER_CENTRE) begin
			if (steering > -zzzap_pkg::STEER_STEP)
				steer_next = zzzap_pkg::STEER_CENTRE;
			else
				steer_next = steering + zzzap_pkg::STEER_STEP;
		end
	end

	// pedal holds its place when released.
	always_comb begin
		pedal_next = pedal;
		if (gas_plus && !gas_minus) begin
			if (pedal > zzzap_pkg::PEDAL_MAX - zzzap_pkg::PEDAL_STEP)
				pedal_next = zzzap_pkg::PEDAL_MAX;
			else
				pedal_next = pedal + zzzap_pkg::PEDAL_STEP;
		end else if (gas_minus && !gas_plus) begin
			if (pedal < zzzap_pkg::PEDAL_STEP)
				pedal_next = '0;
			else
				pedal_next = pedal - zzzap_pkg::PEDAL_STEP;
		end
	end

	always_ff @(posedge clk_core) begin
		if (rst) begin
			vsync_r  <= 1'b0;
			vsync_d  <= 1'b0;
			gear_r   <= 1'b0;
			gear_d   <= 1'b0;
			gear     <= 1'b0;
			steering <= zzzap_pkg::STEER_CENTRE;
			pedal    <= '0;
			pending  <= 1'b0;
			credits  <= zzzap_pkg::CREDIT_INIT;
			push     <= 1'b0;
		end else begin
			vsync_r <= vsync;
			vsync_d <= vsync_r;
			gear_r  <= gear_btn;
			gear_d  <= gear_r;
			gear    <= gear ^ gear_edge;   // low gear / high gear.
			push    <= send;

			if (frame) begin
				steering <= steer_next;
				pedal    <= pedal_next;
				pending  <= 1'b1;          // newer frame overrides an unsent one.
			end else if (send) begin
				pending <= 1'b0;
			end

			case ({send, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// sample payload.
	always_ff @(posedge clk_core) begin
		if (frame)
			pend_data <= {gear, pedal_next, steer_next};
		if (send)
			push_data <= pend_data;
	end

endmodule

// ==== verilog/input_port_mux.sv ====
`timescale 1ns/100ps

// cpu-facing input ports. a latch read takes the oldest buffered sample,
// the other reads report from the latched copy.
module input_port_mux (
	input  logic                           clk_core,
	input  logic                           rst,
	input  logic                           empty,
	input  logic [zzzap_pkg::SAMPLE_W-1:0] head_data,
	input  logic                           port_rd,
	input  zzzap_pkg::port_e               port_sel,
	output logic                           pop,
	output logic                           rd_valid,
	output logic [zzzap_pkg::PORT_W-1:0]   rd_data
);

	logic [zzzap_pkg::SAMPLE_W-1:0] latch;
	logic [zzzap_pkg::STEER_W-1:0]  latch_steer;
	logic [zzzap_pkg::PORT_W-1:0]   steer_adj;
	logic [zzzap_pkg::PORT_W-1:0]   pedal_byte;
	logic                           take;

	// the head only moves after the pop cycle, so a latch read landing on
	// that cycle would see the same entry again. it reports no sample instead.
	assign take = port_rd & (port_sel == zzzap_pkg::PORT_LATCH) & ~empty & ~pop;

	assign latch_steer = latch[zzzap_pkg::STEER_LSB +: zzzap_pkg::STEER_W];

	// range adjust then negate modulo 256.
	assign steer_adj = -(latch_steer + zzzap_pkg::STEER_OFFSET);

	// upper pedal nibble in 3..0, gear in 4.
	assign pedal_byte = {
		3'b000,
		latch[zzzap_pkg::GEAR_BIT],
		latch[zzzap_pkg::PEDAL_LSB + zzzap_pkg::PEDAL_W - 4 +: 4]
	};

	always_ff @(posedge clk_core) begin
		if (rst) begin
			pop      <= 1'b0;
			rd_valid <= 1'b0;
			latch    <= '0;
		end else begin
			pop      <= take;    // doubles as the credit back to the producer.
			rd_valid <= port_rd;
			if (take)
				latch <= head_data;
		end
	end

	// read data is qualified by rd_valid.
	always_ff @(posedge clk_core) begin
		if (port_rd) begin
			case (port_sel)
				zzzap_pkg::PORT_LATCH:
					rd_data <= take ? zzzap_pkg::LATCH_ACK : zzzap_pkg::LATCH_NONE;
				zzzap_pkg::PORT_STEER:
					rd_data <= steer_adj;
				zzzap_pkg::PORT_PEDAL:
					rd_data <= pedal_byte;
				zzzap_pkg::PORT_DIP:
					rd_data <= zzzap_pkg::DIP_DEFAULT;
				default:
					rd_data <= zzzap_pkg::LATCH_NONE;
			endcase
		end
	end

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/100ps

// small circular buffer between the control producer and the cpu port.
// the producer only pushes against a credit, so no full flag is kept.
module sample_fifo (
	input  logic                           clk_core,
	input  logic                           rst,
	input  logic                           push,
	input  logic [zzzap_pkg::SAMPLE_W-1:0] push_data,
	input  logic                           pop,
	output logic                           empty,
	output logic [zzzap_pkg::SAMPLE_W-1:0] head_data
);

	logic [zzzap_pkg::SAMPLE_W-1:0]   mem [zzzap_pkg::FIFO_DEPTH];
	logic [zzzap_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [zzzap_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [zzzap_pkg::CREDIT_W-1:0]   count;  // holds 0..FIFO_DEPTH like the credits.

	function automatic logic [zzzap_pkg::FIFO_PTR_W-1:0] ptr_inc(
		input logic [zzzap_pkg::FIFO_PTR_W-1:0] ptr
	);
		if (ptr == zzzap_pkg::FIFO_LAST)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty     = (count == '0);
	assign head_data = mem[rd_ptr];   // first-word fall-through.

	always_ff @(posedge clk_core) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage.
	always_ff @(posedge clk_core) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// ==== verilog/zzzap_controls.sv ====
`timescale 1ns/100ps

// control input path: button ramp, sample buffer, cpu input ports.
module zzzap_controls (
	input  logic                         clk_core,
	input  logic                         rst,
	input  logic                         vsync,
	input  logic                         gas_plus,
	input  logic                         gas_minus,
	input  logic                         steer_plus,
	input  logic                         steer_minus,
	input  logic                         gear_btn,
	input  logic                         port_rd,
	input  zzzap_pkg::port_e             port_sel,
	output logic                         rd_valid,
	output logic [zzzap_pkg::PORT_W-1:0] rd_data
);

	logic                           push;
	logic [zzzap_pkg::SAMPLE_W-1:0] push_data;
	logic                           pop;
	logic                           empty;
	logic [zzzap_pkg::SAMPLE_W-1:0] head_data;

	control_ramp ramp_i (
		.clk_core      (clk_core),
		.rst           (rst),
		.vsync         (vsync),
		.gas_plus      (gas_plus),
		.gas_minus     (gas_minus),
		.steer_plus    (steer_plus),
		.steer_minus   (steer_minus),
		.gear_btn      (gear_btn),
		.credit_return (pop),        // every pop frees one slot.
		.push          (push),
		.push_data     (push_data)
	);

	sample_fifo fifo_i (
		.clk_core  (clk_core),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.empty     (empty),
		.head_data (head_data)
	);

	input_port_mux port_i (
		.clk_core  (clk_core),
		.rst       (rst),
		.empty     (empty),
		.head_data (head_data),
		.port_rd   (port_rd),
		.port_sel  (port_sel),
		.pop       (pop),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

// ==== verilog/zzzap_pkg.sv ====
package zzzap_pkg;

	// sample fields from high to low are gear, pedal and steering.
	localparam int STEER_W  = 8;
	localparam int PEDAL_W  = 8;
	localparam int SAMPLE_W = 1 + PEDAL_W + STEER_W;

	localparam int STEER_LSB = 0;
	localparam int PEDAL_LSB = STEER_LSB + STEER_W;
	localparam int GEAR_BIT  = PEDAL_LSB + PEDAL_W;

	// steering wheel travel is signed around centre.
	localparam logic signed [STEER_W-1:0] STEER_STEP   = 8'sd8;
	localparam logic signed [STEER_W-1:0] STEER_MAX    = 8'sd64;
	localparam logic signed [STEER_W-1:0] STEER_MIN    = -8'sd64;
	localparam logic signed [STEER_W-1:0] STEER_CENTRE = 8'sd0;

	// pedal travel starts from 0 at rest.
	localparam logic [PEDAL_W-1:0] PEDAL_STEP = 8'd16;
	localparam logic [PEDAL_W-1:0] PEDAL_MAX  = 8'd240;

	// the cpu sees -(steering + offset), giving 30..b0 mapped to 40..c0.
	localparam logic [STEER_W-1:0] STEER_OFFSET = 8'h10;

	// buffer sizing with one credit per slot.
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int CREDIT_W   = 3;

	localparam logic [FIFO_PTR_W-1:0] FIFO_LAST   = FIFO_PTR_W'(FIFO_DEPTH - 1);
	localparam logic [CREDIT_W-1:0]   CREDIT_INIT = CREDIT_W'(FIFO_DEPTH);

	// cpu port data width and fixed replies.
	localparam int PORT_W = 8;

	localparam logic [PORT_W-1:0] DIP_DEFAULT = 8'h3C; // coinage 1/1, 80 s, ext at 2.50, english.
	localparam logic [PORT_W-1:0] LATCH_ACK   = 8'h01;
	localparam logic [PORT_W-1:0] LATCH_NONE  = 8'h00;

	// cpu port opcodes.
	typedef enum logic [1:0] {
		PORT_LATCH = 2'd0, // take the next sample.
		PORT_STEER = 2'd1, // adjusted steering.
		PORT_PEDAL = 2'd2, // pedal nibble and gear.
		PORT_DIP   = 2'd3  // dip switch byte.
	} port_e;

endpackage
